//--- rtl/rob_params.svh
`ifndef ROB_PARAMS_SVH
`define ROB_PARAMS_SVH

// buffer geometry
`define ROB_DEPTH 16
`define ROB_IDX_W 4
`define ROB_LANES 2
`define WB_PORTS 2

// instruction fields
`define XLEN 32
`define ARN_W 5
`define PRN_W 6

`endif

//--- rtl/isa_pkg.sv
`default_nettype none

`include "rob_params.svh"

package isa_pkg;

	typedef logic [`XLEN-1:0] pc_t;
	typedef logic [`ARN_W-1:0] arn_t; // architectural register
	typedef logic [`PRN_W-1:0] prn_t; // physical register

	// halt wins over illegal when both are flagged
	typedef enum logic [1:0] {
		exc_none = 2'd0,
		exc_illegal = 2'd1,
		exc_halt = 2'd2
	} exc_t;

endpackage

`default_nettype wire

//--- rtl/rob_pkg.sv
`default_nettype none

`include "rob_params.svh"

package rob_pkg;

	import isa_pkg::*;

	typedef logic [`ROB_IDX_W-1:0] rob_idx_t;
	typedef logic [`ROB_IDX_W:0] rob_tag_t; // msb is the wrap bit

	typedef struct packed {
		pc_t pc;
		arn_t dest_arn;
		prn_t dest_prn;
		prn_t dest_prn_prev;
	} rob_payload_t;

	typedef struct packed {
		rob_payload_t payload;
		logic branch;
		logic nop;
		logic illegal;
		logic halt;
	} dispatch_t;

	typedef struct packed {
		logic valid;
		logic complete;
		logic branch;
		logic branch_dir;
		logic branch_misp;
		exc_t exc;
		rob_payload_t payload;
	} rob_entry_t;

	typedef struct packed {
		rob_payload_t payload;
		rob_tag_t tag;
		logic branch;
		logic branch_dir;
		logic branch_misp;
		exc_t exc;
		pc_t redirect_pc; // target of the oldest mispredict
	} retire_t;

endpackage

`default_nettype wire

//--- rtl/rob_if.sv
`timescale 1ns/100ps
`default_nettype none

`include "rob_params.svh"

// entry writes from dispatch into the slots
interface alloc_if;
	import rob_pkg::*;

	logic [`ROB_LANES-1:0] wr_en;
	rob_idx_t wr_idx [`ROB_LANES];
	rob_entry_t wr_entry [`ROB_LANES];

	modport src (output wr_en, wr_idx, wr_entry);
	modport dst (input wr_en, wr_idx, wr_entry);
endinterface

// completions, branch result on port 0 only
interface wb_if;
	import isa_pkg::*;
	import rob_pkg::*;

	logic [`WB_PORTS-1:0] wb_valid;
	rob_tag_t wb_tag [`WB_PORTS];
	logic br_misp;
	logic br_dir;
	pc_t redirect_pc;

	modport slot (input wb_valid, wb_tag, br_misp, br_dir);
	modport tracker (input wb_valid, wb_tag, br_misp, redirect_pc);
endinterface

interface retire_if;
	import rob_pkg::*;

	logic [`ROB_LANES-1:0] clr_en; // lane k frees head_idx+k
	rob_idx_t head_idx;
	logic flush; // a retiring entry cut the window

	modport src (output clr_en, head_idx, flush);
	modport slot (input clr_en, head_idx, flush);
endinterface

`default_nettype wire

//--- rtl/dispatch_alloc.sv
`timescale 1ns/100ps
`default_nettype none

`include "rob_params.svh"

module dispatch_alloc (
	input logic clk,
	input logic rst_n,
	input logic pipe_flush,
	input logic [`ROB_LANES-1:0] disp_valid,
	input rob_pkg::dispatch_t disp_pkt [`ROB_LANES],
	output logic [`ROB_LANES-1:0] disp_ready,
	output rob_pkg::rob_tag_t resp_tag [`ROB_LANES],
	input rob_pkg::rob_tag_t head_tag,
	input logic misp_pending,
	alloc_if.src alloc
);
	import isa_pkg::*;
	import rob_pkg::*;

	rob_tag_t tail_q;
	logic [`ROB_IDX_W:0] used_cnt;
	logic [`ROB_IDX_W:0] free_cnt;
	logic [`ROB_LANES-1:0] accept;
	logic [$clog2(`ROB_LANES+1)-1:0] acc_cnt;

	assign used_cnt = tail_q - head_tag; // wrap bit makes full distinct from empty
	assign free_cnt = (`ROB_IDX_W+1)'(`ROB_DEPTH) - used_cnt;

	always_comb begin
		acc_cnt = '0;
		for (int k = 0; k < `ROB_LANES; k++) begin
			// nothing enters while a flush is clearing the buffer
			disp_ready[k] = !misp_pending && !pipe_flush && (free_cnt > {1'b0, rob_idx_t'(k)});
			accept[k] = disp_valid[k] && disp_ready[k];
			resp_tag[k] = tail_q + rob_tag_t'(k);
			acc_cnt = acc_cnt + ($bits(acc_cnt))'(accept[k]);

			alloc.wr_en[k] = accept[k];
			alloc.wr_idx[k] = resp_tag[k][`ROB_IDX_W-1:0];
			alloc.wr_entry[k].valid = 1'b1;
			alloc.wr_entry[k].branch = disp_pkt[k].branch;
			alloc.wr_entry[k].branch_dir = 1'b0;
			alloc.wr_entry[k].branch_misp = 1'b0;
			if (disp_pkt[k].halt) begin
				alloc.wr_entry[k].exc = exc_halt;
			end else if (disp_pkt[k].illegal) begin
				alloc.wr_entry[k].exc = exc_illegal;
			end else begin
				alloc.wr_entry[k].exc = exc_none;
			end
			// no execution needed, goes straight to complete
			alloc.wr_entry[k].complete = disp_pkt[k].nop || (alloc.wr_entry[k].exc != exc_none);
			alloc.wr_entry[k].payload = disp_pkt[k].payload;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tail_q <= '0;
		end else if (pipe_flush) begin
			tail_q <= '0;
		end else begin
			tail_q <= tail_q + rob_tag_t'(acc_cnt);
		end
	end

endmodule

`default_nettype wire

//--- rtl/rob_slot.sv
`timescale 1ns/100ps
`default_nettype none

`include "rob_params.svh"

module rob_slot #(
	parameter int unsigned slot_idx = 0
) (
	input logic clk,
	input logic rst_n,
	input logic pipe_flush,
	alloc_if.dst alloc,
	wb_if.slot wb,
	retire_if.slot ret,
	output rob_pkg::rob_entry_t state
);
	import isa_pkg::*;
	import rob_pkg::*;

	localparam rob_idx_t my_idx = rob_idx_t'(slot_idx);

	logic [`ROB_LANES-1:0] alloc_hit;
	logic [`ROB_LANES-1:0] clr_hit;
	logic [`WB_PORTS-1:0] wb_hit;
	rob_entry_t alloc_entry;
	logic valid_q, complete_q, branch_q, dir_q, misp_q;
	exc_t exc_q;
	rob_payload_t payload_q;

	always_comb begin
		alloc_entry = alloc.wr_entry[0];
		for (int k = 0; k < `ROB_LANES; k++) begin
			alloc_hit[k] = alloc.wr_en[k] && (alloc.wr_idx[k] == my_idx);
			clr_hit[k] = ret.clr_en[k] && (rob_idx_t'(ret.head_idx + rob_idx_t'(k)) == my_idx);
			if (alloc_hit[k]) begin
				alloc_entry = alloc.wr_entry[k];
			end
		end
		for (int p = 0; p < `WB_PORTS; p++) begin
			wb_hit[p] = wb.wb_valid[p] && (wb.wb_tag[p][`ROB_IDX_W-1:0] == my_idx);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
			complete_q <= 1'b0;
			branch_q <= 1'b0;
			dir_q <= 1'b0;
			misp_q <= 1'b0;
			exc_q <= exc_none;
		end else if (pipe_flush) begin
			valid_q <= 1'b0;
			complete_q <= 1'b0;
		end else if (|alloc_hit) begin
			valid_q <= alloc_entry.valid;
			complete_q <= alloc_entry.complete;
			branch_q <= alloc_entry.branch;
			dir_q <= alloc_entry.branch_dir;
			misp_q <= alloc_entry.branch_misp;
			exc_q <= alloc_entry.exc;
		end else begin
			if (valid_q && !complete_q && |wb_hit) begin
				complete_q <= 1'b1;
				if (wb_hit[0]) begin // branch result rides on port 0
					misp_q <= wb.br_misp;
					dir_q <= wb.br_dir;
				end
			end
			// younger entries are wrong path once a cut retires
			if (|clr_hit || ret.flush) begin
				valid_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (|alloc_hit) begin
			payload_q <= alloc_entry.payload;
		end
	end

	always_comb begin
		state.valid = valid_q;
		state.complete = complete_q;
		state.branch = branch_q;
		state.branch_dir = dir_q;
		state.branch_misp = misp_q;
		state.exc = exc_q;
		state.payload = payload_q;
	end

endmodule

`default_nettype wire

//--- rtl/retire_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "rob_params.svh"

module retire_unit (
	input logic clk,
	input logic rst_n,
	input logic pipe_flush,
	input rob_pkg::rob_entry_t slots [`ROB_DEPTH],
	wb_if.tracker wb,
	retire_if.src ret,
	output logic [`ROB_LANES-1:0] ret_valid,
	output rob_pkg::retire_t ret_pkt [`ROB_LANES],
	output rob_pkg::rob_tag_t head_tag,
	output logic misp_pending
);
	import isa_pkg::*;
	import rob_pkg::*;

	rob_tag_t head_q;
	rob_idx_t head_idx;
	rob_entry_t ent [`ROB_LANES];
	logic [`ROB_LANES-1:0] ret_en;
	logic [`ROB_LANES-1:0] cut;
	logic [$clog2(`ROB_LANES+1)-1:0] ret_cnt;
	logic misp_q;
	rob_tag_t misp_tag_q;
	pc_t redirect_q;
	rob_tag_t new_dist;
	rob_tag_t old_dist;
	logic misp_wb;

	assign head_idx = head_q[`ROB_IDX_W-1:0];

	always_comb begin
		for (int k = 0; k < `ROB_LANES; k++) begin
			ent[k] = slots[rob_idx_t'(head_idx + rob_idx_t'(k))];
			cut[k] = ent[k].branch_misp || (ent[k].exc != exc_none);
		end
	end

	// lane 1 needs lane 0 retiring without a cut, and one branch at most
	assign ret_en[0] = ent[0].valid && ent[0].complete;
	assign ret_en[1] = ret_en[0] && !cut[0] && ent[1].valid && ent[1].complete &&
		!(ent[0].branch && ent[1].branch);

	always_comb begin
		ret_cnt = '0;
		for (int k = 0; k < `ROB_LANES; k++) begin
			ret_cnt = ret_cnt + ($bits(ret_cnt))'(ret_en[k]);
			ret_pkt[k].payload = ent[k].payload;
			ret_pkt[k].tag = head_q + rob_tag_t'(k);
			ret_pkt[k].branch = ent[k].branch;
			ret_pkt[k].branch_dir = ent[k].branch_dir;
			ret_pkt[k].branch_misp = ent[k].branch_misp;
			ret_pkt[k].exc = ent[k].exc;
			ret_pkt[k].redirect_pc = redirect_q;
		end
	end

	assign ret_valid = ret_en;
	assign ret.clr_en = ret_en;
	assign ret.head_idx = head_idx;
	assign ret.flush = |(ret_en & cut);

	assign head_tag = head_q;
	assign misp_pending = misp_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			head_q <= '0;
		end else if (pipe_flush) begin
			head_q <= '0;
		end else begin
			head_q <= head_q + rob_tag_t'(ret_cnt);
		end
	end

	// age as distance from head, smaller is older
	assign misp_wb = wb.wb_valid[0] && wb.br_misp;
	assign new_dist = wb.wb_tag[0] - head_q;
	assign old_dist = misp_tag_q - head_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			misp_q <= 1'b0;
			misp_tag_q <= '0;
			redirect_q <= '0;
		end else if (pipe_flush) begin
			misp_q <= 1'b0;
			misp_tag_q <= '0;
			redirect_q <= '0;
		end else if (misp_wb && (!misp_q || new_dist < old_dist)) begin
			misp_q <= 1'b1;
			misp_tag_q <= wb.wb_tag[0];
			redirect_q <= wb.redirect_pc;
		end
	end

endmodule

`default_nettype wire

//--- rtl/rob_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "rob_params.svh"

module rob_top (
	input logic clk,
	input logic rst_n,
	input logic pipe_flush,

	input logic [`ROB_LANES-1:0] disp_valid,
	input rob_pkg::dispatch_t disp_pkt [`ROB_LANES],
	output logic [`ROB_LANES-1:0] disp_ready,
	output rob_pkg::rob_tag_t resp_tag [`ROB_LANES],

	input logic [`WB_PORTS-1:0] wb_valid,
	input rob_pkg::rob_tag_t wb_tag [`WB_PORTS],
	input logic wb_br_misp,
	input logic wb_br_dir,
	input isa_pkg::pc_t wb_redirect_pc,

	output logic [`ROB_LANES-1:0] ret_valid,
	output rob_pkg::retire_t ret_pkt [`ROB_LANES]
);
	import rob_pkg::*;

	alloc_if alloc_bus ();
	wb_if wb_bus ();
	retire_if ret_bus ();

	rob_entry_t slot_state [`ROB_DEPTH];
	rob_tag_t head_tag;
	logic misp_pending;

	assign wb_bus.wb_valid = wb_valid;
	assign wb_bus.wb_tag = wb_tag;
	assign wb_bus.br_misp = wb_br_misp;
	assign wb_bus.br_dir = wb_br_dir;
	assign wb_bus.redirect_pc = wb_redirect_pc;

	dispatch_alloc u_alloc (
		.clk (clk),
		.rst_n (rst_n),
		.pipe_flush (pipe_flush),
		.disp_valid (disp_valid),
		.disp_pkt (disp_pkt),
		.disp_ready (disp_ready),
		.resp_tag (resp_tag),
		.head_tag (head_tag),
		.misp_pending (misp_pending),
		.alloc (alloc_bus)
	);

	for (genvar i = 0; i < `ROB_DEPTH; i++) begin : g_slot
		rob_slot #(
			.slot_idx (i)
		) u_slot (
			.clk (clk),
			.rst_n (rst_n),
			.pipe_flush (pipe_flush),
			.alloc (alloc_bus),
			.wb (wb_bus),
			.ret (ret_bus),
			.state (slot_state[i])
		);
	end

	retire_unit u_retire (
		.clk (clk),
		.rst_n (rst_n),
		.pipe_flush (pipe_flush),
		.slots (slot_state),
		.wb (wb_bus),
		.ret (ret_bus),
		.ret_valid (ret_valid),
		.ret_pkt (ret_pkt),
		.head_tag (head_tag),
		.misp_pending (misp_pending)
	);

endmodule

`default_nettype wire

//--- verification/rob_assertions.sv
`timescale 1ns/100ps
`default_nettype none

`include "rob_params.svh"

module rob_assertions (
	input logic clk,
	input logic rst_n,
	input logic [`ROB_LANES-1:0] ret_valid,
	input rob_pkg::retire_t ret_pkt [`ROB_LANES]
);

	// in-order retirement, lane 1 only ever follows lane 0
	lane_order: assert property (@(posedge clk) disable iff (!rst_n)
		ret_valid[1] |-> ret_valid[0])
		else $error("lane 1 retired without lane 0");

	one_branch: assert property (@(posedge clk) disable iff (!rst_n)
		(ret_valid[1] && ret_pkt[0].branch) |-> !ret_pkt[1].branch)
		else $error("two branches retired in one cycle");

	quiet_in_reset: assert property (@(posedge clk) !rst_n |-> (ret_valid == '0))
		else $error("retire valid while rst_n is low");

endmodule

bind retire_unit rob_assertions u_checks (
	.clk (clk),
	.rst_n (rst_n),
	.ret_valid (ret_valid),
	.ret_pkt (ret_pkt)
);

`default_nettype wire

//--- verification/rob_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "rob_params.svh"

module rob_tb;
	import isa_pkg::*;
	import rob_pkg::*;

	localparam int wait_limit = 64; // cycles before a wait gives up

	logic clk = 1'b0;
	logic rst_n;
	logic pipe_flush;
	logic [`ROB_LANES-1:0] disp_valid;
	dispatch_t disp_pkt [`ROB_LANES];
	logic [`ROB_LANES-1:0] disp_ready;
	rob_tag_t resp_tag [`ROB_LANES];
	logic [`WB_PORTS-1:0] wb_valid;
	rob_tag_t wb_tag [`WB_PORTS];
	logic wb_br_misp;
	logic wb_br_dir;
	pc_t wb_redirect_pc;
	logic [`ROB_LANES-1:0] ret_valid;
	retire_t ret_pkt [`ROB_LANES];

	logic [31:0] seed = 32'ha74a_4d4d;
	int errors;
	int cyc = 0;
	rob_tag_t exp_tail; // tag the next dispatch should receive
	retire_t got_q [$];
	int got_cyc [$];

	rob_top dut0 (
		.clk (clk),
		.rst_n (rst_n),
		.pipe_flush (pipe_flush),
		.disp_valid (disp_valid),
		.disp_pkt (disp_pkt),
		.disp_ready (disp_ready),
		.resp_tag (resp_tag),
		.wb_valid (wb_valid),
		.wb_tag (wb_tag),
		.wb_br_misp (wb_br_misp),
		.wb_br_dir (wb_br_dir),
		.wb_redirect_pc (wb_redirect_pc),
		.ret_valid (ret_valid),
		.ret_pkt (ret_pkt)
	);

	always #50 clk = ~clk;

	always @(posedge clk) cyc <= cyc + 1;

	// retire outputs are settled mid-cycle
	always @(negedge clk) begin
		if (rst_n) begin
			for (int k = 0; k < `ROB_LANES; k++) begin
				if (ret_valid[k]) begin
					got_q.push_back(ret_pkt[k]);
					got_cyc.push_back(cyc);
				end
			end
		end
	end

	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic dispatch_t make_pkt(input logic branch, input logic nop,
		input logic illegal, input logic halt);
		dispatch_t p;
		logic [31:0] r;
		p.payload.pc = pc_t'(next_rand() & 32'hffff_fffc);
		r = next_rand();
		p.payload.dest_arn = r[`ARN_W-1:0];
		p.payload.dest_prn = r[8 +: `PRN_W];
		p.payload.dest_prn_prev = r[16 +: `PRN_W];
		p.branch = branch;
		p.nop = nop;
		p.illegal = illegal;
		p.halt = halt;
		return p;
	endfunction

	// retire packet of an entry that saw no mispredict
	function automatic retire_t expect_of(input dispatch_t p, input rob_tag_t tag);
		retire_t e;
		e = '0;
		e.payload = p.payload;
		e.tag = tag;
		e.branch = p.branch;
		if (p.halt) begin
			e.exc = exc_halt;
		end else if (p.illegal) begin
			e.exc = exc_illegal;
		end else begin
			e.exc = exc_none;
		end
		return e;
	endfunction

	task automatic report_issue(input string msg);
		$display("%0t: %s", $time, msg);
		errors++;
	endtask

	task automatic compare_tag(input string name, input rob_tag_t got, input rob_tag_t exp);
		if (got !== exp) begin
			$display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic compare_retire(input string name, input retire_t got, input retire_t exp);
		if (got !== exp) begin
			$display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic compare_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic finish_test(input string name, input int errs_before);
		if (errors == errs_before) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d error(s)", name, errors - errs_before);
		end
	endtask

	task automatic dispatch_lanes(input int n, input dispatch_t p0, input dispatch_t p1);
		int waited;
		waited = 0;
		@(posedge clk);
		disp_valid <= (n > 1) ? 2'b11 : 2'b01;
		disp_pkt[0] <= p0;
		disp_pkt[1] <= p1;
		@(negedge clk);
		while (!disp_ready[n-1] && waited < wait_limit) begin
			@(negedge clk);
			waited++;
		end
		if (!disp_ready[n-1]) begin
			report_issue("dispatch ready never came up");
		end
		compare_tag("resp_tag[0]", resp_tag[0], exp_tail);
		if (n > 1) begin
			compare_tag("resp_tag[1]", resp_tag[1], exp_tail + rob_tag_t'(1));
		end
		exp_tail = exp_tail + rob_tag_t'(n);
		@(posedge clk); // lanes accepted here
		disp_valid <= '0;
	endtask

	task automatic writeback(input int port, input rob_tag_t tag, input logic misp,
		input logic dir, input pc_t target);
		@(posedge clk);
		wb_valid[port] <= 1'b1;
		wb_tag[port] <= tag;
		wb_br_misp <= misp;
		wb_br_dir <= dir;
		wb_redirect_pc <= target;
		@(posedge clk);
		wb_valid <= '0;
		wb_br_misp <= 1'b0;
	endtask

	task automatic flush_rob();
		@(posedge clk);
		pipe_flush <= 1'b1;
		@(posedge clk);
		pipe_flush <= 1'b0;
		exp_tail = '0;
	endtask

	task automatic wait_retires(input int count);
		int n;
		n = 0;
		while (got_q.size() < count && n < wait_limit) begin
			@(posedge clk);
			n++;
		end
		if (got_q.size() < count) begin
			report_issue("instructions did not retire in time");
		end
	endtask

	task automatic check_alone(input int idx, input string msg);
		for (int i = idx + 1; i < got_q.size(); i++) begin
			if (got_cyc[i] == got_cyc[idx]) begin
				report_issue(msg);
			end
		end
	endtask

	task automatic test_reset();
		int e0;
		e0 = errors;
		@(negedge clk);
		compare_bit("ret_valid[0]", ret_valid[0], 1'b0);
		compare_bit("ret_valid[1]", ret_valid[1], 1'b0);
		compare_bit("disp_ready[0]", disp_ready[0], 1'b1);
		compare_bit("disp_ready[1]", disp_ready[1], 1'b1);
		compare_tag("resp_tag[0]", resp_tag[0], rob_tag_t'(0));
		compare_tag("resp_tag[1]", resp_tag[1], rob_tag_t'(1));
		@(posedge clk);
		finish_test("reset", e0);
	endtask

	task automatic test_in_order();
		int e0;
		int base;
		dispatch_t pkts [6];
		rob_tag_t tags [6];
		e0 = errors;
		base = got_q.size();
		for (int i = 0; i < 6; i++) begin
			pkts[i] = make_pkt(1'b0, 1'b0, 1'b0, 1'b0);
			tags[i] = exp_tail + rob_tag_t'(i);
		end
		for (int i = 0; i < 6; i += 2) begin
			dispatch_lanes(2, pkts[i], pkts[i+1]);
		end
		for (int i = 5; i >= 0; i--) begin
			writeback(i % 2, tags[i], 1'b0, 1'b0, '0);
		end
		wait_retires(base + 6);
		for (int i = 0; i < 6; i++) begin
			if (got_q.size() > base + i) begin
				compare_retire("ret_pkt", got_q[base+i], expect_of(pkts[i], tags[i]));
			end
		end
		finish_test("in-order retire", e0);
	endtask

	task automatic test_branch_limit();
		int e0;
		int base;
		dispatch_t p0;
		dispatch_t p1;
		rob_tag_t t0;
		retire_t e1;
		e0 = errors;
		base = got_q.size();
		p0 = make_pkt(1'b1, 1'b0, 1'b0, 1'b0);
		p1 = make_pkt(1'b1, 1'b0, 1'b0, 1'b0);
		t0 = exp_tail;
		dispatch_lanes(2, p0, p1);
		writeback(0, t0 + rob_tag_t'(1), 1'b0, 1'b1, '0); // younger first, both ready at once
		writeback(0, t0, 1'b0, 1'b0, '0);
		wait_retires(base + 2);
		e1 = expect_of(p1, t0 + rob_tag_t'(1));
		e1.branch_dir = 1'b1;
		if (got_q.size() >= base + 2) begin
			compare_retire("ret_pkt", got_q[base], expect_of(p0, t0));
			compare_retire("ret_pkt", got_q[base+1], e1);
			check_alone(base, "two branches retired in the same cycle");
		end
		finish_test("branch limit", e0);
	endtask

	task automatic test_full();
		int e0;
		int accepted;
		int guard;
		e0 = errors;
		flush_rob();
		accepted = 0;
		guard = 0;
		@(posedge clk);
		disp_valid <= 2'b11;
		disp_pkt[0] <= make_pkt(1'b0, 1'b0, 1'b0, 1'b0);
		disp_pkt[1] <= make_pkt(1'b0, 1'b0, 1'b0, 1'b0);
		@(negedge clk);
		while (disp_ready[0] && guard < wait_limit) begin
			for (int k = 0; k < `ROB_LANES; k++) begin
				if (disp_ready[k]) begin
					compare_tag($sformatf("resp_tag[%0d]", k), resp_tag[k], exp_tail);
					exp_tail = exp_tail + rob_tag_t'(1);
					accepted++;
				end
			end
			@(posedge clk);
			@(negedge clk);
			guard++;
		end
		if (disp_ready[0]) begin
			report_issue("dispatch ready never fell while the buffer filled");
		end
		if (accepted != `ROB_DEPTH) begin
			report_issue($sformatf("buffer accepted %0d entries instead of %0d",
				accepted, `ROB_DEPTH));
		end
		compare_tag("resp_tag[0]", resp_tag[0], rob_tag_t'(`ROB_DEPTH)); // wrap bit set
		@(posedge clk);
		disp_valid <= '0;
		flush_rob();
		finish_test("full buffer", e0);
	endtask

	task automatic test_mispredict();
		int e0;
		int base;
		int guard;
		dispatch_t h;
		dispatch_t b0;
		dispatch_t b1;
		rob_tag_t t0;
		pc_t target_young;
		pc_t target_old;
		retire_t exp;
		retire_t exp_h;
		e0 = errors;
		base = got_q.size();
		h = make_pkt(1'b0, 1'b0, 1'b0, 1'b0);
		b0 = make_pkt(1'b1, 1'b0, 1'b0, 1'b0);
		b1 = make_pkt(1'b1, 1'b0, 1'b0, 1'b0);
		target_young = pc_t'(next_rand() & 32'hffff_fffc);
		target_old = pc_t'(next_rand() & 32'hffff_fffc);
		t0 = exp_tail;
		// head entry holds retirement until both mispredicts are seen
		dispatch_lanes(2, h, b0);
		// nop right behind the older branch would retire with it without the cut
		dispatch_lanes(2, make_pkt(1'b0, 1'b1, 1'b0, 1'b0), b1);
		writeback(0, t0 + rob_tag_t'(3), 1'b1, 1'b1, target_young);
		guard = 0;
		@(negedge clk);
		while (disp_ready[0] && guard < wait_limit) begin
			@(negedge clk);
			guard++;
		end
		compare_bit("disp_ready[0]", disp_ready[0], 1'b0);
		writeback(0, t0 + rob_tag_t'(1), 1'b1, 1'b0, target_old);
		// a younger mispredict reported late must not displace the older one
		writeback(0, t0 + rob_tag_t'(3), 1'b1, 1'b1, target_young);
		writeback(1, t0, 1'b0, 1'b0, '0);
		wait_retires(base + 2);
		repeat (4) @(posedge clk);
		exp_h = expect_of(h, t0);
		exp_h.redirect_pc = target_old;
		exp = expect_of(b0, t0 + rob_tag_t'(1));
		exp.branch_misp = 1'b1;
		exp.redirect_pc = target_old;
		if (got_q.size() > base + 1) begin
			compare_retire("ret_pkt", got_q[base], exp_h);
			compare_retire("ret_pkt", got_q[base+1], exp);
			check_alone(base + 1, "an entry retired together with the mispredicted branch");
		end
		flush_rob();
		@(negedge clk);
		compare_bit("disp_ready[0]", disp_ready[0], 1'b1);
		compare_tag("resp_tag[0]", resp_tag[0], rob_tag_t'(0));
		@(posedge clk);
		finish_test("mispredict", e0);
	endtask

	task automatic test_exception();
		int e0;
		int base;
		dispatch_t p_ill;
		rob_tag_t t0;
		e0 = errors;
		base = got_q.size();
		p_ill = make_pkt(1'b0, 1'b0, 1'b1, 1'b0);
		t0 = exp_tail;
		dispatch_lanes(2, p_ill, make_pkt(1'b0, 1'b1, 1'b0, 1'b0));
		wait_retires(base + 1);
		repeat (4) @(posedge clk);
		if (got_q.size() > base) begin
			compare_retire("ret_pkt", got_q[base], expect_of(p_ill, t0));
			check_alone(base, "the entry behind the exception retired in the same cycle");
		end
		finish_test("exception", e0);
	endtask

	initial begin
		rst_n = 1'b0;
		pipe_flush = 1'b0;
		disp_valid = '0;
		disp_pkt[0] = '0;
		disp_pkt[1] = '0;
		wb_valid = '0;
		wb_tag[0] = '0;
		wb_tag[1] = '0;
		wb_br_misp = 1'b0;
		wb_br_dir = 1'b0;
		wb_redirect_pc = '0;
		errors = 0;
		exp_tail = '0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;

		test_reset();
		test_in_order();
		test_branch_limit();
		test_full();
		test_mispredict();
		test_exception();

		$display("tests run: 6, errors: %0d", errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
+incdir+rtl
rtl/isa_pkg.sv
rtl/rob_pkg.sv
rtl/rob_if.sv
rtl/dispatch_alloc.sv
rtl/rob_slot.sv
rtl/retire_unit.sv
rtl/rob_top.sv
verification/rob_assertions.sv
verification/rob_tb.sv

//--- run.sh
#!/bin/sh
# builds and runs the reorder buffer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module rob_tb -o rob_sim || exit 1

out="$(./obj_dir/rob_sim)"
echo "$out"

echo "$out" | grep -qx "test passed" && exit 0 || exit 1
